// ==== snes_cart_pkg.sv ====
package snes_cart_pkg;

  typedef logic [23:0] snes_addr_t;
  typedef logic [7:0]  byte_t;
  typedef logic [23:0] rom_addr_t;  // word address in [23:1], byte lane in [0]
  typedef logic [18:0] ram_addr_t;

  //////////////////////////////////////////////////////////////////////
  // console address map
  //////////////////////////////////////////////////////////////////////

  localparam snes_addr_t REG_BANK_ADDR   = 24'h002A00;
  localparam snes_addr_t REG_LINEAR_ADDR = 24'h002A01;
  localparam snes_addr_t REG_IRQ_ADDR    = 24'h002A02;

  localparam byte_t SRAM_BANK_LO = 8'h70;  // save ram below $8000 in these banks
  localparam byte_t SRAM_BANK_HI = 8'h7D;

  //////////////////////////////////////////////////////////////////////
  // memory wait states, in CLK2 cycles
  //////////////////////////////////////////////////////////////////////

  localparam logic [3:0] ROM_RD_WAIT  = 4'd4;
  localparam logic [3:0] ROM_WR_WAIT1 = 4'd2;  // address setup before data
  localparam logic [3:0] ROM_WR_WAIT2 = 4'd3;  // data hold to we_n rising
  localparam logic [3:0] MCU_WAIT     = 4'd6;
  localparam logic [3:0] MCU_TAIL     = 4'd2;

  localparam int IRQ_LEN = 256;  // one full turn of the 8-bit irq counter

  typedef enum logic [7:0] {
    IDLE          = 8'b0000_0001,
    SNES_RD       = 8'b0000_0010,
    SNES_WR_ADDR  = 8'b0000_0100,
    SNES_WR_DATA  = 8'b0000_1000,
    SNES_WR_END   = 8'b0001_0000,
    MCU_ACCESS    = 8'b0010_0000,
    MCU_TAIL_WAIT = 8'b0100_0000,
    MCU_RSP       = 8'b1000_0000
  } seq_state_t;

  typedef enum logic [1:0] {SEL_NONE, SEL_ROM, SEL_RAM} mem_sel_t;

endpackage

// ==== snes_map_if.sv ====
`timescale 1ns/1ps

interface snes_map_if import snes_cart_pkg::*; ();

  mem_sel_t  sel;       // which memory the console address hits
  rom_addr_t rom_addr;
  ram_addr_t ram_addr;
  logic      reg_hit;   // one of the cart registers

  modport decoder (
    output sel,
    output rom_addr,
    output ram_addr,
    output reg_hit
  );

  // reg_hit is picked up by the register block at the top level
  modport sequencer (
    input sel,
    input rom_addr,
    input ram_addr
  );

endinterface

// ==== snes_bus_sync.sv ====
`timescale 1ns/1ps

module snes_bus_sync #(
  parameter int SYNC_DEPTH = 6
) (
  input  logic CLK2,
  input  logic snes_read,
  input  logic snes_write,
  input  logic snes_cpu_clk,
  output logic rd_start,
  output logic wr_start,
  output logic wr_end,
  output logic cycle_start
);

  localparam int NUM_STROBES = 3;

  // oldest sample still at the old level, every newer one at the new level,
  // so a change is only reported once it has been stable for a while
  localparam logic [SYNC_DEPTH-1:0] FALL_PAT = {1'b1, {(SYNC_DEPTH-1){1'b0}}};
  localparam logic [SYNC_DEPTH-1:0] RISE_PAT = ~FALL_PAT;

  logic [NUM_STROBES-1:0]                 strobe;
  logic [NUM_STROBES-1:0][SYNC_DEPTH-1:0] shift;
  logic [NUM_STROBES-1:0]                 fell;
  logic [NUM_STROBES-1:0]                 rose;

  assign strobe = {snes_cpu_clk, snes_write, snes_read};

  always_ff @(posedge CLK2) begin
    for (int i = 0; i < NUM_STROBES; i++) begin
      shift[i] <= {shift[i][SYNC_DEPTH-2:0], strobe[i]};  // newest in bit 0
    end
  end

  for (genvar i = 0; i < NUM_STROBES; i++) begin : g_edge
    assign fell[i] = (shift[i] == FALL_PAT);
    assign rose[i] = (shift[i] == RISE_PAT);
  end

  assign rd_start    = fell[0];
  assign wr_start    = fell[1];
  assign wr_end      = rose[1];
  assign cycle_start = rose[2];  // console address valid from here on

endmodule

// ==== snes_addr_decode.sv ====
`timescale 1ns/1ps

module snes_addr_decode import snes_cart_pkg::*; (
  input  snes_addr_t         snes_addr,
  input  byte_t              rom_bank,
  input  logic               linear,
  snes_map_if.decoder        map
);

  byte_t       bank;
  logic [15:0] offset;
  logic        sram_hit;
  logic        rom_hit;

  assign bank   = snes_addr[23:16];
  assign offset = snes_addr[15:0];

  // save ram window, lower half of banks $70-$7D
  assign sram_hit = (bank >= SRAM_BANK_LO) && (bank <= SRAM_BANK_HI) && !offset[15];

  // lorom upper halves plus the whole of $C0-$FF
  assign rom_hit = !sram_hit && (offset[15] || (bank >= 8'hC0));

  assign map.reg_hit = (snes_addr == REG_BANK_ADDR)
                    || (snes_addr == REG_LINEAR_ADDR)
                    || (snes_addr == REG_IRQ_ADDR);

  assign map.sel = sram_hit ? SEL_RAM : (rom_hit ? SEL_ROM : SEL_NONE);

  // linear mode opens a flat 64k window into the bank picked by the register
  assign map.rom_addr = linear ? {rom_bank, offset}
                               : {2'b00, bank[6:0], offset[14:0]};

  assign map.ram_addr = {bank[3:0], offset[14:0]};

endmodule

// ==== snes_ctrl_regs.sv ====
`timescale 1ns/1ps

module snes_ctrl_regs import snes_cart_pkg::*; (
  input  logic       CLK2,
  input  logic       reset,
  input  logic       wr_end,
  input  snes_addr_t snes_addr,
  input  byte_t      snes_data_in,
  input  logic       reg_hit,
  output byte_t      rom_bank,
  output logic       linear,
  output logic       snes_irq
);

  logic       reg_wr;
  logic       irq_start;
  logic [7:0] irq_cnt;  // cycles left in the pulse

  assign reg_wr    = wr_end && reg_hit;  // console write just completed
  assign irq_start = reg_wr && (snes_addr == REG_IRQ_ADDR);

  always_ff @(posedge CLK2) begin
    if (reset) begin
      rom_bank <= '0;
      linear   <= 1'b0;
    end else if (reg_wr) begin
      if (snes_addr == REG_BANK_ADDR) rom_bank <= snes_data_in;
      if (snes_addr == REG_LINEAR_ADDR) linear <= snes_data_in[0];
    end
  end

  // irq pulse retriggered by any write to the irq register
  always_ff @(posedge CLK2) begin
    if (reset) begin
      snes_irq <= 1'b0;
      irq_cnt  <= '0;
    end else if (irq_start) begin
      snes_irq <= 1'b1;
      irq_cnt  <= 8'(IRQ_LEN - 1);
    end else if (snes_irq) begin
      if (irq_cnt == '0) snes_irq <= 1'b0;
      else irq_cnt <= irq_cnt - 8'd1;
    end
  end

  // a pulse never ends before IRQ_LEN cycles
  irq_pulse_len: assert property (@(posedge CLK2) disable iff (reset)
    $fell(snes_irq) |-> $past(snes_irq, IRQ_LEN))
    else $error("snes_irq pulse shorter than IRQ_LEN cycles");

endmodule

// ==== mem_sequencer.sv ====
`timescale 1ns/1ps

module mem_sequencer import snes_cart_pkg::*; #(
  parameter logic [3:0] RD_WAIT = ROM_RD_WAIT
) (
  input  logic          CLK2,
  input  logic          reset,
  snes_map_if.sequencer map,
  input  logic          rd_start,
  input  logic          wr_start,
  input  logic          cycle_start,
  input  byte_t         snes_data_in,
  output byte_t         snes_data_out,
  output logic          snes_data_oe,
  // psram, 16 bit with byte lanes
  output logic [22:0]   rom_addr,
  input  logic [15:0]   rom_dq_in,
  output logic [15:0]   rom_dq_out,
  output logic          rom_we_n,
  output logic          rom_bhe_n,
  output logic          rom_ble_n,
  // save ram
  output ram_addr_t     ram_addr,
  input  byte_t         ram_dq_in,
  output byte_t         ram_dq_out,
  output logic          ram_we_n,
  // mcu port
  input  logic          mcu_req_valid,
  output logic          mcu_req_ready,
  input  logic          mcu_write,
  input  logic          mcu_ramsel,
  input  rom_addr_t     mcu_addr,
  input  byte_t         mcu_wdata,
  output logic          mcu_rsp_valid,
  input  logic          mcu_rsp_ready,
  output byte_t         mcu_rdata
);

  seq_state_t state;
  logic [3:0] wait_cnt;
  logic       rd_pend;
  logic       wr_pend;
  logic       snes_pend;  // console cycle with a memory hit not yet served
  logic       rd_go;
  logic       wr_go;
  logic       rd_take;
  logic       wr_take;
  logic       start_rd;
  logic       start_wr;
  logic       start_mcu;
  logic       acc_ram;
  logic       acc_write;
  rom_addr_t  rom_addr_q;
  ram_addr_t  ram_addr_q;
  byte_t      wdata_q;
  byte_t      mem_byte;

  //////////////////////////////////////////////////////////////////////
  // arbitration, console first
  //////////////////////////////////////////////////////////////////////

  assign rd_go   = rd_start || rd_pend;
  assign wr_go   = wr_start || wr_pend;
  assign rd_take = (state == IDLE) && rd_go;
  assign wr_take = (state == IDLE) && !rd_go && wr_go;

  assign start_rd = rd_take && (map.sel != SEL_NONE);  // register hits need no memory
  assign start_wr = wr_take && (map.sel != SEL_NONE);

  assign mcu_req_ready = (state == IDLE) && !rd_go && !wr_go && !snes_pend;
  assign start_mcu     = mcu_req_valid && mcu_req_ready;
  assign mcu_rsp_valid = (state == MCU_RSP);

  always_ff @(posedge CLK2) begin
    if (reset) begin
      rd_pend      <= 1'b0;
      wr_pend      <= 1'b0;
      snes_pend    <= 1'b0;
      snes_data_oe <= 1'b0;
    end else begin
      if (rd_take) rd_pend <= 1'b0;
      else if (rd_start) rd_pend <= 1'b1;  // arrived mid mcu access
      if (wr_take) wr_pend <= 1'b0;
      else if (wr_start) wr_pend <= 1'b1;
      if (cycle_start) snes_pend <= (map.sel != SEL_NONE);
      else if (rd_take || wr_take) snes_pend <= 1'b0;
      if (cycle_start || wr_start) snes_data_oe <= 1'b0;
      else if (rd_start && (map.sel != SEL_NONE)) snes_data_oe <= 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // access FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    if (reset) begin
      state    <= IDLE;
      wait_cnt <= '0;
      rom_we_n <= 1'b1;
      ram_we_n <= 1'b1;
    end else begin
      case (state)
        IDLE: begin
          if (start_rd) begin
            state    <= SNES_RD;
            wait_cnt <= RD_WAIT;
          end else if (start_wr) begin
            state    <= SNES_WR_ADDR;
            wait_cnt <= ROM_WR_WAIT1;
            rom_we_n <= (map.sel != SEL_ROM);
            ram_we_n <= (map.sel != SEL_RAM);
          end else if (start_mcu) begin
            state    <= MCU_ACCESS;
            wait_cnt <= MCU_WAIT;
            rom_we_n <= !(mcu_write && !mcu_ramsel);
            ram_we_n <= !(mcu_write && mcu_ramsel);
          end
        end
        SNES_RD: begin
          if (wait_cnt == '0) state <= IDLE;
          else wait_cnt <= wait_cnt - 4'd1;
        end
        SNES_WR_ADDR: begin
          if (wait_cnt == '0) state <= SNES_WR_DATA;
          else wait_cnt <= wait_cnt - 4'd1;
        end
        SNES_WR_DATA: begin
          state    <= SNES_WR_END;
          wait_cnt <= ROM_WR_WAIT2;
        end
        SNES_WR_END: begin
          if (wait_cnt == '0) begin
            state    <= IDLE;
            rom_we_n <= 1'b1;
            ram_we_n <= 1'b1;
          end else begin
            wait_cnt <= wait_cnt - 4'd1;
          end
        end
        MCU_ACCESS: begin
          if (wait_cnt == '0) begin
            state    <= MCU_TAIL_WAIT;
            wait_cnt <= MCU_TAIL;
            rom_we_n <= 1'b1;
            ram_we_n <= 1'b1;
          end else begin
            wait_cnt <= wait_cnt - 4'd1;
          end
        end
        MCU_TAIL_WAIT: begin
          if (wait_cnt == '0) state <= MCU_RSP;
          else wait_cnt <= wait_cnt - 4'd1;
        end
        MCU_RSP: begin
          if (mcu_rsp_ready) state <= IDLE;  // console waits behind this
        end
        default: state <= IDLE;
      endcase
    end
  end

  // address and data registers
  always_ff @(posedge CLK2) begin
    if (start_rd || start_wr) begin
      rom_addr_q <= map.rom_addr;
      ram_addr_q <= map.ram_addr;
      acc_ram    <= (map.sel == SEL_RAM);
    end else if (start_mcu) begin
      rom_addr_q <= mcu_addr;
      ram_addr_q <= mcu_addr[18:0];
      acc_ram    <= mcu_ramsel;
      acc_write  <= mcu_write;
      wdata_q    <= mcu_wdata;
    end
    if (state == SNES_WR_DATA) wdata_q <= snes_data_in;
    if ((state == SNES_RD) && (wait_cnt == '0)) snes_data_out <= mem_byte;
    if ((state == MCU_ACCESS) && (wait_cnt == '0) && !acc_write) mcu_rdata <= mem_byte;
  end

  // odd addresses sit in the low lane
  assign mem_byte = acc_ram ? ram_dq_in
                            : (rom_addr_q[0] ? rom_dq_in[7:0] : rom_dq_in[15:8]);

  assign rom_addr   = rom_addr_q[23:1];
  assign rom_dq_out = rom_addr_q[0] ? {8'h00, wdata_q} : {wdata_q, 8'h00};
  assign rom_bhe_n  = rom_we_n ? 1'b0 : rom_addr_q[0];  // both lanes on for reads
  assign rom_ble_n  = rom_we_n ? 1'b0 : ~rom_addr_q[0];
  assign ram_addr   = ram_addr_q;
  assign ram_dq_out = wdata_q;

  state_onehot: assert property (@(posedge CLK2) disable iff (reset) $onehot(state))
    else $error("sequencer state not one-hot");

  one_write_at_a_time: assert property (@(posedge CLK2) disable iff (reset)
    !(!rom_we_n && !ram_we_n))
    else $error("rom and ram written together");

endmodule

// ==== snes_cart_top.sv ====
`timescale 1ns/1ps

module snes_cart_top import snes_cart_pkg::*; #(
  parameter int         SYNC_DEPTH = 6,
  parameter logic [3:0] RD_WAIT    = ROM_RD_WAIT
) (
  input  logic        CLK2,
  input  logic        reset,
  // console bus
  input  snes_addr_t  snes_addr,
  input  logic        snes_read,
  input  logic        snes_write,
  input  logic        snes_cpu_clk,
  input  byte_t       snes_data_in,
  output byte_t       snes_data_out,
  output logic        snes_data_oe,
  output logic        snes_irq,
  // psram
  output logic [22:0] rom_addr,
  input  logic [15:0] rom_dq_in,
  output logic [15:0] rom_dq_out,
  output logic        rom_we_n,
  output logic        rom_bhe_n,
  output logic        rom_ble_n,
  // save ram
  output ram_addr_t   ram_addr,
  input  byte_t       ram_dq_in,
  output byte_t       ram_dq_out,
  output logic        ram_we_n,
  // mcu port
  input  logic        mcu_req_valid,
  output logic        mcu_req_ready,
  input  logic        mcu_write,
  input  logic        mcu_ramsel,
  input  rom_addr_t   mcu_addr,
  input  byte_t       mcu_wdata,
  output logic        mcu_rsp_valid,
  input  logic        mcu_rsp_ready,
  output byte_t       mcu_rdata
);

  logic  rd_start;
  logic  wr_start;
  logic  wr_end;
  logic  cycle_start;
  byte_t rom_bank;
  logic  linear;

  snes_map_if map_bus ();

  snes_bus_sync #(
    .SYNC_DEPTH (SYNC_DEPTH)
  ) u_bus_sync (
    .CLK2        (CLK2),
    .snes_read   (snes_read),
    .snes_write  (snes_write),
    .snes_cpu_clk(snes_cpu_clk),
    .rd_start    (rd_start),
    .wr_start    (wr_start),
    .wr_end      (wr_end),
    .cycle_start (cycle_start)
  );

  snes_addr_decode u_addr_decode (
    .snes_addr(snes_addr),
    .rom_bank (rom_bank),
    .linear   (linear),
    .map      (map_bus.decoder)
  );

  snes_ctrl_regs u_ctrl_regs (
    .CLK2        (CLK2),
    .reset       (reset),
    .wr_end      (wr_end),
    .snes_addr   (snes_addr),
    .snes_data_in(snes_data_in),
    .reg_hit     (map_bus.reg_hit),
    .rom_bank    (rom_bank),
    .linear      (linear),
    .snes_irq    (snes_irq)
  );

  mem_sequencer #(
    .RD_WAIT (RD_WAIT)
  ) u_mem_sequencer (
    .CLK2         (CLK2),
    .reset        (reset),
    .map          (map_bus.sequencer),
    .rd_start     (rd_start),
    .wr_start     (wr_start),
    .cycle_start  (cycle_start),
    .snes_data_in (snes_data_in),
    .snes_data_out(snes_data_out),
    .snes_data_oe (snes_data_oe),
    .rom_addr     (rom_addr),
    .rom_dq_in    (rom_dq_in),
    .rom_dq_out   (rom_dq_out),
    .rom_we_n     (rom_we_n),
    .rom_bhe_n    (rom_bhe_n),
    .rom_ble_n    (rom_ble_n),
    .ram_addr     (ram_addr),
    .ram_dq_in    (ram_dq_in),
    .ram_dq_out   (ram_dq_out),
    .ram_we_n     (ram_we_n),
    .mcu_req_valid(mcu_req_valid),
    .mcu_req_ready(mcu_req_ready),
    .mcu_write    (mcu_write),
    .mcu_ramsel   (mcu_ramsel),
    .mcu_addr     (mcu_addr),
    .mcu_wdata    (mcu_wdata),
    .mcu_rsp_valid(mcu_rsp_valid),
    .mcu_rsp_ready(mcu_rsp_ready),
    .mcu_rdata    (mcu_rdata)
  );

endmodule

// ==== tb_snes_cart_tests.svh ====
  //////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic reset_values();
    check_bit("reset rom_we_n", 1'b1, rom_we_n);
    check_bit("reset ram_we_n", 1'b1, ram_we_n);
    check_bit("reset mcu_rsp_valid", 1'b0, mcu_rsp_valid);
    check_bit("reset snes_irq", 1'b0, snes_irq);
    check_bit("reset mcu_req_ready", 1'b1, mcu_req_ready);
  endtask

  task automatic lorom_read_lanes();
    snes_addr_t a;
    a = 24'h018000 | snes_addr_t'($urandom & 32'h7FFE);  // even, upper half
    console_read("lorom even lane", a, rom_fill(lorom_map(a)));
    a = a | 24'h000001;
    console_read("lorom odd lane", a, rom_fill(lorom_map(a)));
    a = 24'hC30000 | snes_addr_t'($urandom & 32'h7FFF);  // low half of a $C0+ bank
    console_read("lorom high bank", a, rom_fill(lorom_map(a)));
  endtask

  task automatic sram_write_read();
    snes_addr_t a;
    ram_addr_t  ra;
    byte_t      d;
    a  = 24'h720000 | snes_addr_t'($urandom & 32'h7FFF);
    ra = {a[19:16], a[14:0]};
    d  = byte_t'($urandom);
    if (d == ram_mem[ra]) d = ~d;  // make the write visible
    console_write(a, d);
    check_byte("sram model", d, ram_mem[ra]);
    console_read("sram readback", a, d);
  endtask

  task automatic linear_bank_read();
    byte_t      bank;
    snes_addr_t a;
    bank = byte_t'($urandom);
    console_write(REG_BANK_ADDR, bank);
    console_write(REG_LINEAR_ADDR, 8'h01);
    a = 24'h059ABC;
    console_read("linear upper half", a, rom_fill({bank, a[15:0]}));
    a = 24'hC31235;
    console_read("linear high bank", a, rom_fill({bank, a[15:0]}));
    console_write(REG_LINEAR_ADDR, 8'h00);  // back to lorom
    a = 24'h059ABC;
    console_read("lorom restored", a, rom_fill(lorom_map(a)));
  endtask

  task automatic irq_pulse();
    int n;
    int high;
    console_write(REG_IRQ_ADDR, 8'h00);
    n = 0;
    while (!snes_irq) begin
      if (n == TIMEOUT) timed_out("snes_irq to rise");
      n++;
      tick();
    end
    high = 0;
    while (snes_irq) begin
      if (high == 300) timed_out("snes_irq to fall");
      high++;
      tick();
    end
    check_bit("irq held 200 cycles", 1'b1, high >= 200);
  endtask

  task automatic mcu_roundtrip();
    rom_addr_t a;
    byte_t     d;
    byte_t     r;
    a = rom_addr_t'($urandom);
    d = ~rom_fill(a);
    mcu_access("mcu rom write", 1'b1, 1'b0, a, d, 0, r);
    check_byte("rom model", d, a[0] ? rom_mem[a[23:1]][7:0] : rom_mem[a[23:1]][15:8]);
    mcu_access("mcu rom read", 1'b0, 1'b0, a, 8'h00, 4, r);
    check_byte("mcu rom read", d, r);
    // other lane of the same word
    mcu_access("mcu rom other lane", 1'b0, 1'b0, a ^ 24'h000001, 8'h00, 0, r);
    check_byte("mcu rom other lane", rom_fill(a ^ 24'h000001), r);
    a = rom_addr_t'($urandom & 32'h7FFFF);
    d = ~ram_mem[a[18:0]];
    mcu_access("mcu ram write", 1'b1, 1'b1, a, d, 3, r);
    check_byte("ram model", d, ram_mem[a[18:0]]);
    mcu_access("mcu ram read", 1'b0, 1'b1, a, 8'h00, 6, r);
    check_byte("mcu ram read", d, r);
  endtask

// ==== tb_snes_cart.sv ====
`timescale 1ns/1ps

module tb_snes_cart import snes_cart_pkg::*; ();

  localparam int         SYNC_DEPTH = 6;
  localparam logic [3:0] RD_WAIT    = ROM_RD_WAIT;
  localparam int         TIMEOUT    = 100;  // cycles per wait loop

  logic        CLK2 = 1'b0;
  logic        reset;
  snes_addr_t  snes_addr;
  logic        snes_read;
  logic        snes_write;
  logic        snes_cpu_clk;
  byte_t       snes_data_in;
  byte_t       snes_data_out;
  logic        snes_data_oe;
  logic        snes_irq;
  logic [22:0] rom_addr;
  logic [15:0] rom_dq_in;
  logic [15:0] rom_dq_out;
  logic        rom_we_n;
  logic        rom_bhe_n;
  logic        rom_ble_n;
  ram_addr_t   ram_addr;
  byte_t       ram_dq_in;
  byte_t       ram_dq_out;
  logic        ram_we_n;
  logic        mcu_req_valid;
  logic        mcu_req_ready;
  logic        mcu_write;
  logic        mcu_ramsel;
  rom_addr_t   mcu_addr;
  byte_t       mcu_wdata;
  logic        mcu_rsp_valid;
  logic        mcu_rsp_ready;
  byte_t       mcu_rdata;

  logic [15:0] rom_mem [0:(1<<23)-1];  // even byte in [15:8]
  byte_t       ram_mem [0:(1<<19)-1];

  always #5 CLK2 = ~CLK2;

  snes_cart_top #(
    .SYNC_DEPTH (SYNC_DEPTH),
    .RD_WAIT    (RD_WAIT)
  ) i_dut (.*);

  //////////////////////////////////////////////////////////////////////
  // memory models
  //////////////////////////////////////////////////////////////////////

  function automatic byte_t rom_fill(rom_addr_t a);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ 8'h3C;
  endfunction

  function automatic byte_t ram_fill(ram_addr_t a);
    return a[7:0] ^ a[15:8] ^ {5'd0, a[18:16]} ^ 8'hA5;
  endfunction

  initial begin
    for (int w = 0; w < (1 << 23); w++) begin
      rom_mem[w[22:0]] = {rom_fill({w[22:0], 1'b0}), rom_fill({w[22:0], 1'b1})};
    end
    for (int a = 0; a < (1 << 19); a++) begin
      ram_mem[a[18:0]] = ram_fill(a[18:0]);
    end
  end

  assign rom_dq_in = rom_mem[rom_addr];
  assign ram_dq_in = ram_mem[ram_addr];

  always @(posedge CLK2) begin
    if (!rom_we_n && !rom_bhe_n) rom_mem[rom_addr][15:8] = rom_dq_out[15:8];
    if (!rom_we_n && !rom_ble_n) rom_mem[rom_addr][7:0] = rom_dq_out[7:0];
    if (!ram_we_n) ram_mem[ram_addr] = ram_dq_out;
  end

  //////////////////////////////////////////////////////////////////////
  // checks and bus drivers
  //////////////////////////////////////////////////////////////////////

  task automatic fail_stop();
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic timed_out(input string what);
    $display("timeout while waiting for %s", what);
    fail_stop();
  endtask

  task automatic check_byte(input string name, input byte_t exp, input byte_t act);
    if (act !== exp) begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      fail_stop();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Fail %s: expected %b, actual %b", name, exp, act);
      fail_stop();
    end
  endtask

  task automatic tick(input int n = 1);
    repeat (n) @(posedge CLK2);
    #1;  // drive and sample just after the edge
  endtask

  function automatic logic sram_hit(snes_addr_t a);
    return (a[23:16] >= SRAM_BANK_LO) && (a[23:16] <= SRAM_BANK_HI) && !a[15];
  endfunction

  function automatic rom_addr_t lorom_map(snes_addr_t a);
    return {2'b00, a[22:16], a[14:0]};
  endfunction

  // address phase of a console cycle
  task automatic bus_cycle(input snes_addr_t addr);
    snes_addr    = addr;
    snes_cpu_clk = 1'b0;
    tick(SYNC_DEPTH + 2);
    snes_cpu_clk = 1'b1;
    tick(SYNC_DEPTH + 2);
  endtask

  task automatic console_read(input string name, input snes_addr_t addr, input byte_t exp);
    int n;
    bus_cycle(addr);
    snes_read = 1'b0;
    n = 0;
    while (!snes_data_oe) begin
      if (n == TIMEOUT) timed_out("snes_data_oe");
      n++;
      tick();
    end
    tick(int'(RD_WAIT) + 2);  // byte captured by now
    check_bit({name, " oe"}, 1'b1, snes_data_oe);
    check_byte(name, exp, snes_data_out);
    snes_read = 1'b1;
    tick(SYNC_DEPTH + 2);
  endtask

  task automatic console_write(input snes_addr_t addr, input byte_t data);
    int n;
    bus_cycle(addr);
    snes_data_in = data;
    snes_write   = 1'b0;
    if (sram_hit(addr)) begin
      n = 0;
      while (ram_we_n) begin
        if (n == TIMEOUT) timed_out("ram_we_n to fall");
        n++;
        tick();
      end
      n = 0;
      while (!ram_we_n) begin
        if (n == TIMEOUT) timed_out("ram_we_n to rise");
        n++;
        tick();
      end
    end else begin
      tick(SYNC_DEPTH + 2);  // register write, no memory pulse
    end
    snes_write = 1'b1;
    tick(SYNC_DEPTH + 2);  // registers load after wr_end
  endtask

  task automatic mcu_access(input string name, input logic write, input logic ramsel,
                            input rom_addr_t addr, input byte_t wdata, input int stall,
                            output byte_t rdata);
    int n;
    mcu_write     = write;
    mcu_ramsel    = ramsel;
    mcu_addr      = addr;
    mcu_wdata     = wdata;
    mcu_req_valid = 1'b1;
    n = 0;
    while (!mcu_req_ready) begin
      if (n == TIMEOUT) timed_out("mcu_req_ready");
      n++;
      tick();
    end
    tick();  // accepted on this edge
    mcu_req_valid = 1'b0;
    n = 0;
    while (!mcu_rsp_valid) begin
      check_bit({name, " req_ready busy"}, 1'b0, mcu_req_ready);
      if (n == TIMEOUT) timed_out("mcu_rsp_valid");
      n++;
      tick();
    end
    repeat (stall) begin
      tick();
      check_bit({name, " rsp held"}, 1'b1, mcu_rsp_valid);
      check_bit({name, " req_ready stalled"}, 1'b0, mcu_req_ready);
    end
    rdata         = mcu_rdata;
    mcu_rsp_ready = 1'b1;
    tick();
    mcu_rsp_ready = 1'b0;
    check_bit({name, " rsp taken"}, 1'b0, mcu_rsp_valid);
    check_bit({name, " req_ready again"}, 1'b1, mcu_req_ready);
  endtask

  `include "tb_snes_cart_tests.svh"

  initial begin
    void'($urandom(52));
    reset         = 1'b1;
    snes_addr     = '0;
    snes_read     = 1'b1;
    snes_write    = 1'b1;
    snes_cpu_clk  = 1'b1;
    snes_data_in  = '0;
    mcu_req_valid = 1'b0;
    mcu_write     = 1'b0;
    mcu_ramsel    = 1'b0;
    mcu_addr      = '0;
    mcu_wdata     = '0;
    mcu_rsp_ready = 1'b0;
    tick(3);
    reset = 1'b0;
    tick(SYNC_DEPTH + 4);  // strobe synchronizers filled
    reset_values();
    lorom_read_lanes();
    sram_write_read();
    linear_bank_read();
    irq_pulse();
    mcu_roundtrip();
    $display("No errors");
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+.
snes_cart_pkg.sv
snes_map_if.sv
snes_bus_sync.sv
snes_addr_decode.sv
snes_ctrl_regs.sv
mem_sequencer.sv
snes_cart_top.sv
tb_snes_cart.sv

// ==== run.sh ====
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_snes_cart -f flist.f > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed"
  exit 1
fi

./obj_dir/Vtb_snes_cart > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "Errors found" sim.log; then
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi
exit 0
